// ==== source/aether_cmd_pkg.sv ====
package aether_cmd_pkg;

  // Command port widths
  localparam int InstrWidth = 4;
  localparam int Param1Width = 4;
  localparam int Param2Width = 16;

  // ------------------------------------------------
  // Opcodes on instruction_i
  // ------------------------------------------------
  localparam logic [InstrWidth-1:0] OpNop = 4'd0;
  localparam logic [InstrWidth-1:0] OpRst = 4'd1;     // Reset, kind in param_1
  localparam logic [InstrWidth-1:0] OpWrg = 4'd2;
  localparam logic [InstrWidth-1:0] OpRrg = 4'd3;
  localparam logic [InstrWidth-1:0] OpLdwStrt = 4'd4;
  localparam logic [InstrWidth-1:0] OpLdwCont = 4'd5;
  localparam logic [InstrWidth-1:0] OpLipStrt = 4'd6;
  localparam logic [InstrWidth-1:0] OpLipCont = 4'd7;
  localparam logic [InstrWidth-1:0] OpCnvRun = 4'd8;
  localparam logic [InstrWidth-1:0] OpRdo = 4'd9;     // Result index in param_2

  // Register map
  localparam logic [Param1Width-1:0] RegVersn = 4'd0;
  localparam logic [Param1Width-1:0] RegHwrid = 4'd1;
  localparam logic [Param1Width-1:0] RegBcfg2 = 4'd2; // Matrix side
  localparam logic [Param1Width-1:0] RegStats = 4'd3;

  localparam logic [Param2Width-1:0] VersnValue = 16'h6C00;
  localparam logic [Param2Width-1:0] HwridValue = 16'hB2E9;
  localparam int MatrixSizeReset = 8;

  // Reset kinds for OpRst
  localparam logic [Param1Width-1:0] RstConv = 4'd1;
  localparam logic [Param1Width-1:0] RstRegs = 4'd2;
  localparam logic [Param1Width-1:0] RstFull = 4'd3;  // Conv, regs and load counters

endpackage

// ==== source/aether_conv_pkg.sv ====
package aether_conv_pkg;

  // Datapath widths
  localparam int DataWidth = 8;
  localparam int ResultWidth = 16;
  localparam int AccWidth = 20;      // Nine full-scale products fit

  // Kernel geometry
  localparam int KernelSize = 3;
  localparam int KernelTaps = 9;
  localparam int KernelWords = 5;    // Top byte of last word unused

  // Matrix and memory sizes
  localparam int MaxMatrixSize = 16;
  localparam int MinMatrixSize = 3;
  localparam int InputWords = 128;   // Two activations per word
  localparam int BufAddrWidth = 7;
  localparam int ResultDepth = 196;  // (16 - 2) squared
  localparam int ResultAddrWidth = 8;

  typedef logic signed [DataWidth-1:0] data_t;
  typedef logic signed [ResultWidth-1:0] result_t;
  typedef logic [4:0] msize_t;

  // Even element in the low byte
  typedef struct packed {
    data_t hi;
    data_t lo;
  } act_pair_t;

  typedef union packed {
    logic [15:0] raw;
    act_pair_t pair;
  } act_word_u;

endpackage

// ==== source/input_buffer.sv ====
`timescale 1ns/1ps

module input_buffer (
    input  logic clk_i,
    input  logic rst_i,
    input  logic start_i,
    input  logic cont_i,
    input  aether_conv_pkg::act_word_u word_i,
    input  logic [aether_conv_pkg::BufAddrWidth-1:0] rd_addr_i,
    output aether_conv_pkg::act_word_u rd_word_o
  );

  logic [aether_conv_pkg::BufAddrWidth-1:0] wr_addr;
  logic full;                     // Last address written
  logic wr_en;
  aether_conv_pkg::act_word_u mem [aether_conv_pkg::InputWords];

  assign wr_en = cont_i && !full; // Extra words are dropped

  always_ff @(posedge clk_i)
  begin
    if (rst_i || start_i)
    begin
      wr_addr <= '0;
      full <= 1'b0;
    end
    else if (wr_en)
    begin
      if (wr_addr == aether_conv_pkg::InputWords - 1)
        full <= 1'b1;
      else
        wr_addr <= wr_addr + 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (wr_en)
      mem[wr_addr] <= word_i;
    rd_word_o <= mem[rd_addr_i];  // Engine read port
  end

  // Counter parks on the last address once full
  assert property (@(posedge clk_i) disable iff (rst_i)
    full |-> wr_addr == aether_conv_pkg::InputWords - 1);

endmodule

// ==== source/conv_kernel_store.sv ====
`timescale 1ns/1ps

module conv_kernel_store (
    input  logic clk_i,
    input  logic rst_i,
    input  logic start_i,
    input  logic cont_i,
    input  aether_conv_pkg::act_word_u word_i,
    output aether_conv_pkg::data_t taps_o [aether_conv_pkg::KernelTaps]
  );

  logic [$clog2(aether_conv_pkg::KernelWords+1)-1:0] word_idx;
  logic wr_en;
  aether_conv_pkg::act_word_u words [aether_conv_pkg::KernelWords];

  assign wr_en = cont_i && (word_idx < aether_conv_pkg::KernelWords);

  always_ff @(posedge clk_i)
  begin
    if (rst_i || start_i)
      word_idx <= '0;
    else if (wr_en)
      word_idx <= word_idx + 1'b1;
  end

  always_ff @(posedge clk_i)
  begin
    if (wr_en)
      words[word_idx] <= word_i;
  end

  // Two taps per word, even tap in the low byte
  always_comb
  begin
    for (int t = 0; t < aether_conv_pkg::KernelTaps; t++)
    begin
      if (t[0])
        taps_o[t] = words[t/2].pair.hi;
      else
        taps_o[t] = words[t/2].pair.lo;
    end
  end

endmodule

// ==== source/conv_engine.sv ====
`timescale 1ns/1ps

module conv_engine (
    input  logic clk_i,
    input  logic rst_i,
    input  logic run_i,
    input  aether_conv_pkg::msize_t matrix_size_i,
    input  aether_conv_pkg::data_t taps_i [aether_conv_pkg::KernelTaps],
    input  aether_conv_pkg::act_word_u buf_word_i,
    input  logic rd_en_i,
    input  aether_conv_pkg::act_word_u rd_addr_i,
    output logic [aether_conv_pkg::BufAddrWidth-1:0] buf_addr_o,
    output logic running_o,
    output logic done_o,
    output aether_conv_pkg::result_t rd_data_o
  );

  aether_conv_pkg::msize_t n_q;   // Side latched at start
  logic issuing;
  logic [3:0] row;
  logic [3:0] col;
  logic [1:0] ki;
  logic [1:0] kj;
  logic tap_first;
  logic tap_last;
  logic pos_last;
  logic [aether_conv_pkg::BufAddrWidth:0] elem_idx;
  logic [aether_conv_pkg::ResultAddrWidth-1:0] res_addr;

  // Stage behind the buffer read
  logic valid_d;
  logic first_d;
  logic last_d;
  logic final_d;
  logic sel_d;
  aether_conv_pkg::data_t tap_d;
  logic [aether_conv_pkg::ResultAddrWidth-1:0] res_addr_d;

  aether_conv_pkg::data_t act;
  logic signed [2*aether_conv_pkg::DataWidth-1:0] prod;
  logic signed [aether_conv_pkg::AccWidth-1:0] acc;
  logic signed [aether_conv_pkg::AccWidth-1:0] base;
  logic signed [aether_conv_pkg::AccWidth-1:0] sum;
  aether_conv_pkg::result_t sat;
  aether_conv_pkg::result_t res_mem [aether_conv_pkg::ResultDepth];

  // ------------------------------------------------
  // Address generation
  // ------------------------------------------------
  assign tap_first = (ki == 2'd0) && (kj == 2'd0);
  assign tap_last = (ki == 2'(aether_conv_pkg::KernelSize - 1)) &&
                    (kj == 2'(aether_conv_pkg::KernelSize - 1));
  assign pos_last = ({1'b0, row} == n_q - 5'd3) && ({1'b0, col} == n_q - 5'd3);

  // Element (r+i)*N + c+j with two per buffer word
  assign elem_idx = ({4'd0, row} + {6'd0, ki}) * {3'd0, n_q} + {4'd0, col} + {6'd0, kj};
  assign buf_addr_o = elem_idx[aether_conv_pkg::BufAddrWidth:1];
  assign res_addr = {4'd0, row} * ({3'd0, n_q} - 8'd2) + {4'd0, col};

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      n_q <= '0;
      issuing <= 1'b0;
      running_o <= 1'b0;
      done_o <= 1'b0;
      valid_d <= 1'b0;
      row <= '0;
      col <= '0;
      ki <= '0;
      kj <= '0;
    end
    else
    begin
      valid_d <= issuing;
      if (run_i && !running_o)
      begin
        n_q <= matrix_size_i;
        row <= '0;
        col <= '0;
        ki <= '0;
        kj <= '0;
        issuing <= 1'b1;
        running_o <= 1'b1;
        done_o <= 1'b0;
      end
      else if (issuing)
      begin
        if (kj != 2'(aether_conv_pkg::KernelSize - 1))
          kj <= kj + 1'b1;
        else
        begin
          kj <= '0;
          if (ki != 2'(aether_conv_pkg::KernelSize - 1))
            ki <= ki + 1'b1;
          else
          begin
            ki <= '0;
            if (pos_last)
              issuing <= 1'b0;    // Pipeline still drains one word
            else if ({1'b0, col} == n_q - 5'd3)
            begin
              col <= '0;
              row <= row + 1'b1;
            end
            else
              col <= col + 1'b1;
          end
        end
      end
      if (valid_d && final_d)
      begin
        running_o <= 1'b0;
        done_o <= 1'b1;           // Held until next run or reset
      end
    end
  end

  // ------------------------------------------------
  // Multiply-accumulate and saturation
  // ------------------------------------------------
  always_ff @(posedge clk_i)
  begin
    tap_d <= taps_i[ki*aether_conv_pkg::KernelSize + kj];
    sel_d <= elem_idx[0];         // Odd element in the high byte
    first_d <= tap_first;
    last_d <= tap_last;
    final_d <= tap_last && pos_last;
    res_addr_d <= res_addr;
    if (valid_d)
      acc <= sum;
  end

  assign act = sel_d ? buf_word_i.pair.hi : buf_word_i.pair.lo;
  assign prod = act * tap_d;

  always_comb
  begin
    base = acc;
    if (first_d)
      base = '0;
    sum = base + prod;
    if (sum[aether_conv_pkg::AccWidth-1] &&
        !(&sum[aether_conv_pkg::AccWidth-2:aether_conv_pkg::ResultWidth-1]))
      sat = {1'b1, {(aether_conv_pkg::ResultWidth-1){1'b0}}};
    else if (!sum[aether_conv_pkg::AccWidth-1] &&
             (|sum[aether_conv_pkg::AccWidth-2:aether_conv_pkg::ResultWidth-1]))
      sat = {1'b0, {(aether_conv_pkg::ResultWidth-1){1'b1}}};
    else
      sat = sum[aether_conv_pkg::ResultWidth-1:0];
  end

  // Row-major result memory
  always_ff @(posedge clk_i)
  begin
    if (valid_d && last_d)
      res_mem[res_addr_d] <= sat;
    if (rd_en_i)
      rd_data_o <= res_mem[rd_addr_i.raw[aether_conv_pkg::ResultAddrWidth-1:0]];
  end

  // Reads stay inside the words loaded for this matrix
  assert property (@(posedge clk_i) disable iff (rst_i)
    issuing |-> int'(buf_addr_o) < (int'(n_q) * int'(n_q) + 1) / 2);

  assert property (@(posedge clk_i) disable iff (rst_i)
    (valid_d && last_d) |-> res_addr_d < aether_conv_pkg::ResultDepth);

endmodule

// ==== source/aether_engine_decoder.sv ====
`timescale 1ns/1ps

module aether_engine_decoder (
    input  logic clk_i,
    input  logic rst_i,
    input  logic [aether_cmd_pkg::InstrWidth-1:0] instruction_i,
    input  logic [aether_cmd_pkg::Param1Width-1:0] param_1_i,
    input  logic [aether_cmd_pkg::Param2Width-1:0] param_2_i,
    input  logic conv_running_i,
    input  logic conv_done_i,
    input  aether_conv_pkg::result_t rd_data_i,
    output logic rst_conv_o,
    output logic rst_load_o,
    output logic ldw_strt_o,
    output logic ldw_cont_o,
    output logic lip_strt_o,
    output logic lip_cont_o,
    output logic cnv_run_o,
    output logic rd_en_o,
    output aether_conv_pkg::act_word_u cmd_word_o,
    output aether_conv_pkg::msize_t matrix_size_o,
    output logic [aether_cmd_pkg::Param2Width-1:0] data_o,
    output logic interrupt_o
  );

  logic [aether_cmd_pkg::InstrWidth-1:0] instr_q;
  logic [aether_cmd_pkg::Param1Width-1:0] sel_q;    // param_1 of the command
  logic is_rst;
  logic rst_regs;
  logic bcfg2_wr;
  aether_conv_pkg::msize_t bcfg2;
  logic [aether_cmd_pkg::Param2Width-1:0] stats;
  logic [aether_cmd_pkg::Param2Width-1:0] reg_rd;
  logic [aether_cmd_pkg::Param2Width-1:0] reg_rd_q;
  logic rrg_q;
  logic rdo_q;

  // ------------------------------------------------
  // Command capture
  // ------------------------------------------------
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      instr_q <= aether_cmd_pkg::OpNop;
    else
      instr_q <= instruction_i;    // Held for one cycle only
  end

  always_ff @(posedge clk_i)
  begin
    sel_q <= param_1_i;
    cmd_word_o.raw <= param_2_i;
  end

  assign is_rst = instr_q == aether_cmd_pkg::OpRst;

  assign rst_conv_o = rst_i || (is_rst && (sel_q == aether_cmd_pkg::RstConv ||
                                           sel_q == aether_cmd_pkg::RstFull));
  assign rst_regs = rst_i || (is_rst && (sel_q == aether_cmd_pkg::RstRegs ||
                                         sel_q == aether_cmd_pkg::RstFull));
  assign rst_load_o = rst_i || (is_rst && sel_q == aether_cmd_pkg::RstFull);

  assign ldw_strt_o = instr_q == aether_cmd_pkg::OpLdwStrt;
  assign ldw_cont_o = instr_q == aether_cmd_pkg::OpLdwCont;
  assign lip_strt_o = instr_q == aether_cmd_pkg::OpLipStrt;
  assign lip_cont_o = instr_q == aether_cmd_pkg::OpLipCont;
  assign cnv_run_o = instr_q == aether_cmd_pkg::OpCnvRun;
  assign rd_en_o = instr_q == aether_cmd_pkg::OpRdo;

  // ------------------------------------------------
  // Register file
  // ------------------------------------------------

  // Out-of-range sizes keep the old value
  assign bcfg2_wr = instr_q == aether_cmd_pkg::OpWrg && sel_q == aether_cmd_pkg::RegBcfg2 &&
                    cmd_word_o.raw >= aether_conv_pkg::MinMatrixSize &&
                    cmd_word_o.raw <= aether_conv_pkg::MaxMatrixSize;

  always_ff @(posedge clk_i)
  begin
    if (rst_regs)
      bcfg2 <= aether_conv_pkg::msize_t'(aether_cmd_pkg::MatrixSizeReset);
    else if (bcfg2_wr)
      bcfg2 <= cmd_word_o.raw[$bits(bcfg2)-1:0];
  end

  assign matrix_size_o = bcfg2;
  assign stats = {{(aether_cmd_pkg::Param2Width-2){1'b0}}, conv_running_i, conv_done_i};
  assign interrupt_o = conv_done_i;

  always_comb
  begin
    case (sel_q)
      aether_cmd_pkg::RegVersn: reg_rd = aether_cmd_pkg::VersnValue;
      aether_cmd_pkg::RegHwrid: reg_rd = aether_cmd_pkg::HwridValue;
      aether_cmd_pkg::RegBcfg2:
        reg_rd = {{(aether_cmd_pkg::Param2Width-$bits(bcfg2)){1'b0}}, bcfg2};
      aether_cmd_pkg::RegStats: reg_rd = stats;
      default: reg_rd = '0;        // Unmapped
    endcase
  end

  // Read pipeline puts data_o two cycles after the command
  always_ff @(posedge clk_i)
  begin
    if (instr_q == aether_cmd_pkg::OpRrg)
      reg_rd_q <= reg_rd;
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      rrg_q <= 1'b0;
      rdo_q <= 1'b0;
      data_o <= '0;
    end
    else
    begin
      rrg_q <= instr_q == aether_cmd_pkg::OpRrg;
      rdo_q <= rd_en_o;
      if (rrg_q)
        data_o <= reg_rd_q;
      else if (rdo_q)
        data_o <= rd_data_i;     // Engine result arrives one cycle after rd_en
    end
  end

  // BCFG2 only ever holds a legal matrix side
  assert property (@(posedge clk_i) disable iff (rst_i)
    bcfg2 >= aether_conv_pkg::MinMatrixSize && bcfg2 <= aether_conv_pkg::MaxMatrixSize);

endmodule

// ==== source/aether_engine.sv ====
`timescale 1ns/1ps

module aether_engine (
    input  logic clk_i,
    input  logic rst_i,
    input  logic [aether_cmd_pkg::InstrWidth-1:0] instruction_i,
    input  logic [aether_cmd_pkg::Param1Width-1:0] param_1_i,
    input  logic [aether_cmd_pkg::Param2Width-1:0] param_2_i,
    output logic [aether_cmd_pkg::Param2Width-1:0] data_o,
    output logic interrupt_o
  );

  // Strobes from the decoder
  logic rst_conv;
  logic rst_load;
  logic ldw_strt;
  logic ldw_cont;
  logic lip_strt;
  logic lip_cont;
  logic cnv_run;
  logic rd_en;
  aether_conv_pkg::act_word_u cmd_word;   // Load word or result index
  aether_conv_pkg::msize_t matrix_size;

  // Datapath
  logic [aether_conv_pkg::BufAddrWidth-1:0] buf_rd_addr;
  aether_conv_pkg::act_word_u buf_word;
  aether_conv_pkg::data_t taps [aether_conv_pkg::KernelTaps];
  logic conv_running;
  logic conv_done;
  aether_conv_pkg::result_t rd_data;

  // ------------------------------------------------
  // Decoder and registers
  // ------------------------------------------------
  aether_engine_decoder i_decoder (
    .clk_i,
    .rst_i,
    .instruction_i,
    .param_1_i,
    .param_2_i,
    .conv_running_i(conv_running),
    .conv_done_i(conv_done),
    .rd_data_i(rd_data),
    .rst_conv_o(rst_conv),
    .rst_load_o(rst_load),
    .ldw_strt_o(ldw_strt),
    .ldw_cont_o(ldw_cont),
    .lip_strt_o(lip_strt),
    .lip_cont_o(lip_cont),
    .cnv_run_o(cnv_run),
    .rd_en_o(rd_en),
    .cmd_word_o(cmd_word),
    .matrix_size_o(matrix_size),
    .data_o,
    .interrupt_o
  );

  // ------------------------------------------------
  // Activation buffer and kernel
  // ------------------------------------------------
  input_buffer i_input_buffer (
    .clk_i,
    .rst_i(rst_load),
    .start_i(lip_strt),
    .cont_i(lip_cont),
    .word_i(cmd_word),
    .rd_addr_i(buf_rd_addr),
    .rd_word_o(buf_word)
  );

  conv_kernel_store i_kernel_store (
    .clk_i,
    .rst_i(rst_load),
    .start_i(ldw_strt),
    .cont_i(ldw_cont),
    .word_i(cmd_word),
    .taps_o(taps)
  );

  conv_engine i_conv_engine (
    .clk_i,
    .rst_i(rst_conv),
    .run_i(cnv_run),
    .matrix_size_i(matrix_size),
    .taps_i(taps),
    .buf_word_i(buf_word),
    .rd_en_i(rd_en),
    .rd_addr_i(cmd_word),
    .buf_addr_o(buf_rd_addr),
    .running_o(conv_running),
    .done_o(conv_done),
    .rd_data_o(rd_data)
  );

endmodule

// ==== verif/aether_engine_tb.sv ====
`timescale 1ns/1ps

module aether_engine_tb;

  localparam int DoneTimeout = 5000;      // Cycles, a 16x16 run needs about 1800
  localparam logic [31:0] SeedInit = 32'hf460_0d93;
  localparam int ActDepth = aether_conv_pkg::MaxMatrixSize * aether_conv_pkg::MaxMatrixSize;

  logic clk_i = 1'b0;
  logic rst_i;
  logic [aether_cmd_pkg::InstrWidth-1:0] instruction_i;
  logic [aether_cmd_pkg::Param1Width-1:0] param_1_i;
  logic [aether_cmd_pkg::Param2Width-1:0] param_2_i;
  logic [aether_cmd_pkg::Param2Width-1:0] data_o;
  logic interrupt_o;

  int errors = 0;
  int tests = 0;
  int failed_tests = 0;
  bit abort = 1'b0;
  logic [31:0] rng_state;
  int act_mem [ActDepth];                 // Model copy of the activations
  int wgt [aether_conv_pkg::KernelTaps];
  int cur_size;

  aether_engine i_aether_engine (
    .clk_i,
    .rst_i,
    .instruction_i,
    .param_1_i,
    .param_2_i,
    .data_o,
    .interrupt_o
  );

  always #4 clk_i = ~clk_i;

  // --------------------------------------------------
  // Stimulus data and reference model
  // --------------------------------------------------
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int next_byte();
    rng_state = xorshift(rng_state);
    return int'($signed(rng_state[7:0]));
  endfunction

  // Even element goes to the low byte
  function automatic logic [15:0] pack_pair(input int lo, input int hi);
    return {hi[7:0], lo[7:0]};
  endfunction

  function automatic int conv_model(input int n, input int r, input int c);
    int s;
    s = 0;
    for (int i = 0; i < 3; i++)
      for (int j = 0; j < 3; j++)
        s += act_mem[(r + i) * n + c + j] * wgt[i * 3 + j];
    if (s > 32767)
      s = 32767;                          // Clamp to 16 bits signed
    else if (s < -32768)
      s = -32768;
    return s;
  endfunction

  task automatic make_data(input int n, input int seed, input logic [63:0] mode,
                           input bit with_acts);
    rng_state = SeedInit ^ seed;
    if (rng_state == 0)
      rng_state = SeedInit;
    if (with_acts)
      for (int k = 0; k < n * n; k++)
        act_mem[k] = (mode == "extreme") ? ((seed == 0) ? -128 : 127) : next_byte();
    for (int k = 0; k < aether_conv_pkg::KernelTaps; k++)
      wgt[k] = (mode == "extreme") ? -128 : next_byte();
  endtask

  // --------------------------------------------------
  // Command port access
  // --------------------------------------------------
  task automatic issue(input logic [3:0] op, input logic [3:0] p1, input logic [15:0] p2);
    @(posedge clk_i);
    instruction_i <= op;
    param_1_i <= p1;
    param_2_i <= p2;
    @(posedge clk_i);
    instruction_i <= aether_cmd_pkg::OpNop;   // One cycle strobe
  endtask

  // data_o settles two edges after the sampling edge
  task automatic read_data(output logic [15:0] value);
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    value = data_o;
  endtask

  task automatic read_reg(input logic [3:0] addr, output logic [15:0] value);
    issue(aether_cmd_pkg::OpRrg, addr, '0);
    read_data(value);
  endtask

  task automatic read_result(input int idx, output logic [15:0] value);
    issue(aether_cmd_pkg::OpRdo, '0, idx[15:0]);
    read_data(value);
  endtask

  task automatic load_input(input int n);
    int hi;
    issue(aether_cmd_pkg::OpLipStrt, '0, '0);
    for (int w = 0; w < (n * n + 1) / 2; w++)
    begin
      hi = (2 * w + 1 < n * n) ? act_mem[2 * w + 1] : 0;
      issue(aether_cmd_pkg::OpLipCont, '0, pack_pair(act_mem[2 * w], hi));
    end
  endtask

  task automatic load_kernel();
    int hi;
    issue(aether_cmd_pkg::OpLdwStrt, '0, '0);
    for (int w = 0; w < aether_conv_pkg::KernelWords; w++)
    begin
      hi = (2 * w + 1 < aether_conv_pkg::KernelTaps) ? wgt[2 * w + 1] : 0;
      issue(aether_cmd_pkg::OpLdwCont, '0, pack_pair(wgt[2 * w], hi));
    end
  endtask

  task automatic check_word(input string name, input logic [15:0] got,
                            input logic [15:0] exp);
    if (got !== exp)
    begin
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_result(input int idx, input aether_conv_pkg::result_t got,
                              input aether_conv_pkg::result_t exp);
    if (got !== exp)
    begin
      $display("** Error at %0t: data_o result %0d = %0d, expected %0d",
               $time, idx, got, exp);
      errors++;
    end
  endtask

  task automatic wait_for_interrupt(output bit ok);
    int n;
    ok = 1'b0;
    n = 0;
    while (!ok && n < DoneTimeout)
    begin
      @(negedge clk_i);
      n++;
      if (interrupt_o)
        ok = 1'b1;
    end
  endtask

  task automatic run_and_check(input int n);
    bit ok;
    logic [15:0] got;
    aether_conv_pkg::result_t got_res;
    aether_conv_pkg::result_t exp_res;
    issue(aether_cmd_pkg::OpCnvRun, '0, '0);
    read_reg(aether_cmd_pkg::RegStats, got);
    check_word("data_o (STATS)", got, 16'h0002);   // Running, not yet done
    wait_for_interrupt(ok);
    if (!ok)
    begin
      $display("Timeout: interrupt_o did not rise within %0d cycles of the run", DoneTimeout);
      errors++;
      abort = 1'b1;
    end
    else
    begin
      read_reg(aether_cmd_pkg::RegStats, got);
      check_word("data_o (STATS)", got, 16'h0001);
      for (int r = 0; r < n - 2; r++)
        for (int c = 0; c < n - 2; c++)
        begin
          read_result(r * (n - 2) + c, got);
          got_res = got;
          exp_res = conv_model(n, r, c);
          check_result(r * (n - 2) + c, got_res, exp_res);
        end
    end
  endtask

  // --------------------------------------------------
  // Test sequence from the tests file
  // --------------------------------------------------
  initial
  begin
    int fd;
    int code;
    int nf;
    int want;
    int a;
    int v;
    int e;
    int err_before;
    logic [63:0] kind;
    logic [63:0] mode;
    logic [8*128-1:0] skip_line;
    logic [15:0] got;
    string desc;
    rst_i = 1'b1;
    instruction_i = aether_cmd_pkg::OpNop;
    param_1_i = '0;
    param_2_i = '0;
    rng_state = SeedInit;
    cur_size = 0;
    code = 0;
    repeat (10) @(posedge clk_i);
    rst_i <= 1'b0;
    fd = $fopen("verif/aether_engine_tests.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open verif/aether_engine_tests.txt");
      errors++;
    end
    else
      code = $fscanf(fd, "%s", kind);
    while (!abort && code == 1)
    begin
      if (kind == "#")
        code = $fgets(skip_line, fd);       // Comment line
      else
      begin
        err_before = errors;
        nf = 1;
        want = 1;
        if (kind == "rrd")
        begin
          nf = $fscanf(fd, "%h %h", a, e);
          want = 2;
        end
        else if (kind == "wrg")
        begin
          nf = $fscanf(fd, "%h %h %h", a, v, e);
          want = 3;
        end
        else if (kind == "irq")
        begin
          nf = $fscanf(fd, "%d", e);
        end
        else if (kind == "cnv")
        begin
          nf = $fscanf(fd, "%d %d %s", a, v, mode);
          want = 3;
        end
        else if (kind == "krn")
          nf = $fscanf(fd, "%d", v);
        if (nf != want)
        begin
          $display("Malformed line in the tests file after test %0d", tests);
          errors++;
          abort = 1'b1;
        end
        else if (kind == "rrd")
        begin
          desc = "register read";
          read_reg(a, got);
          check_word("data_o", got, e);
        end
        else if (kind == "wrg")
        begin
          desc = "register write";
          issue(aether_cmd_pkg::OpWrg, a, v);
          read_reg(a, got);
          check_word("data_o", got, e);
        end
        else if (kind == "irq")
        begin
          desc = "interrupt level";
          @(negedge clk_i);
          check_word("interrupt_o", {15'd0, interrupt_o}, e);
        end
        else if (kind == "cnv")
        begin
          desc = (mode == "extreme") ? "saturating convolution" : "random convolution";
          cur_size = a;
          make_data(a, v, mode, 1'b1);
          issue(aether_cmd_pkg::OpWrg, aether_cmd_pkg::RegBcfg2, a);
          load_input(a);
          load_kernel();
          run_and_check(a);
        end
        else if (kind == "krn")
        begin
          desc = "kernel reload";
          make_data(cur_size, v, "random", 1'b0);   // Activations stay as loaded
          load_kernel();
          run_and_check(cur_size);
        end
        else if (kind == "rcv")
        begin
          desc = "engine reset";
          issue(aether_cmd_pkg::OpRst, aether_cmd_pkg::RstConv, '0);
          read_reg(aether_cmd_pkg::RegStats, got);
          check_word("data_o (STATS)", got, 16'h0000);
          check_word("interrupt_o", {15'd0, interrupt_o}, 16'h0000);
        end
        else
        begin
          $display("Unknown test kind in the tests file after test %0d", tests);
          errors++;
          abort = 1'b1;
        end
        if (!abort || errors != err_before)
        begin
          tests++;
          if (errors == err_before)
            $display("Test %0d %s: PASS", tests, desc);
          else
          begin
            failed_tests++;
            $display("Test %0d %s: FAIL", tests, desc);
          end
        end
      end
      if (!abort)
        code = $fscanf(fd, "%s", kind);
    end
    if (fd != 0)
      $fclose(fd);
    $display("%0d tests run, %0d failed, %0d check errors", tests, failed_tests, errors);
    if (errors == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

// ==== verif/aether_engine_tests.txt ====
# Kinds: rrd addr expect | wrg addr value expect | irq level | cnv size seed mode | krn seed | rcv
# Register fields hex, sizes and seeds decimal; extreme seed 0 is all -128, else acts 127
rrd 0 6c00
rrd 1 b2e9
rrd 2 0008
rrd 3 0000
rrd 9 0000
irq 0
wrg 2 000c 000c
wrg 2 0002 000c
wrg 2 0011 000c
wrg 2 0003 0003
wrg 0 1234 6c00
wrg 1 0000 b2e9
wrg 7 ffff 0000
cnv 3 11 random
irq 1
cnv 8 22 random
cnv 16 33 random
cnv 6 0 extreme
cnv 5 1 extreme
rcv
irq 0
krn 44
cnv 7 55 random
rcv
krn 66

// ==== aether_engine.f ====
source/aether_cmd_pkg.sv
source/aether_conv_pkg.sv
source/input_buffer.sv
source/conv_kernel_store.sv
source/conv_engine.sv
source/aether_engine_decoder.sv
source/aether_engine.sv
verif/aether_engine_tb.sv

// ==== Bender.yml ====
package:
  name: aether_engine

sources:
  - source/aether_cmd_pkg.sv
  - source/aether_conv_pkg.sv
  - source/input_buffer.sv
  - source/conv_kernel_store.sv
  - source/conv_engine.sv
  - source/aether_engine_decoder.sv
  - source/aether_engine.sv
  - target: simulation
    files:
      - verif/aether_engine_tb.sv
